/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_np2_mem -f tb.f -Mdir obj_dir -o tb_np2_mem
./obj_dir/tb_np2_mem > sim.log 2>&1
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

/* source/np2_addr_ramwrap.sv */
`timescale 1ns/1ps
`default_nettype none

module np2_addr_ramwrap #(
  parameter int NUMADDR = 8192,
  parameter int BITADDR = 13,
  parameter int NUMVBNK = 8,
  parameter int BITVBNK = 3,
  parameter int BITPBNK = BITVBNK,
  parameter int NUMVROW = 1024,
  parameter int BITVROW = 10,
  localparam int LBITPBK = (BITPBNK > 0) ? BITPBNK : 1
) (
  input  logic [BITADDR-1:0] vaddr,
  output logic [LBITPBK-1:0] vbadr,
  output logic [BITVROW-1:0] vradr
);

  localparam int MAPW = LBITPBK + BITVROW;

  // Splits the low nbnk*NUMVROW addresses by walking the set bits of NUMVROW.
  // Each set bit b owns a slab of 2**b rows in every bank, stacked above the slabs
  // of the higher bits, so each address lands on exactly one bank and row.
  function automatic logic [MAPW-1:0] split_np2(input logic [BITADDR-1:0] addr,
                                                input int nbnk);
    int lo_rows;
    int hi_rows;
    logic [LBITPBK-1:0] bnk;
    logic [BITVROW-1:0] row;
    bnk = '1;
    row = '0;
    for (int b = 0; b < BITVROW; b++) begin
      if (((NUMVROW >> b) & 1) != 0) begin
        lo_rows = NUMVROW & ~((1 << b) - 1);
        hi_rows = NUMVROW & ~((1 << (b + 1)) - 1);
        if (int'(addr) < nbnk * lo_rows) begin
          bnk = LBITPBK'((int'(addr) - nbnk * hi_rows) >> b);
          row = BITVROW'((int'(addr) & ((1 << b) - 1)) | hi_rows);
        end
      end
    end
    return {bnk, row};
  endfunction

  generate
    if (BITVBNK == 0) begin : g_one_bank
      always_comb begin
        vbadr = '0;
        vradr = BITVROW'(vaddr);
      end
    end else begin : g_banked
      always_comb begin
        vbadr = '1;
        vradr = '0;
        if (NUMVBNK * NUMVROW == NUMADDR) begin
          // Geometry fills the address space exactly.
          if (NUMVROW == (1 << BITVROW)) begin
            vbadr = LBITPBK'(vaddr >> BITVROW);
            vradr = BITVROW'(vaddr);
          end else if (NUMVBNK == (1 << BITVBNK)) begin
            vbadr = LBITPBK'(vaddr & ((1 << BITVBNK) - 1));
            vradr = BITVROW'(vaddr >> BITVBNK);
          end else begin
            {vbadr, vradr} = split_np2(vaddr, NUMVBNK);
          end
        end else begin
          // The last bank is filled linearly and the rest share the split rules.
          if (int'(vaddr) >= NUMVBNK * NUMVROW) begin
            vbadr = '1;
            vradr = '0;
          end else if (int'(vaddr) >= (NUMVBNK - 1) * NUMVROW) begin
            vbadr = LBITPBK'(NUMVBNK - 1);
            vradr = BITVROW'(int'(vaddr) - (NUMVBNK - 1) * NUMVROW);
          end else if (NUMVROW == (1 << BITVROW)) begin
            vbadr = LBITPBK'(vaddr >> BITVROW);
            vradr = BITVROW'(vaddr);
          end else if ((NUMVBNK - 1) == (1 << BITVBNK)) begin
            vbadr = LBITPBK'(vaddr & ((1 << BITVBNK) - 1));
            vradr = BITVROW'(vaddr >> BITVBNK);
          end else begin
            {vbadr, vradr} = split_np2(vaddr, NUMVBNK - 1);
          end
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

/* source/np2_bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module np2_bank_ram
  import np2_op_pkg::*;
#(
  parameter int NUMVROW = 12,
  parameter int BITVROW = 4
) (
  input  logic              clk,
  input  logic              we,
  input  logic [BITVROW-1:0] row,
  input  logic [DATA_W-1:0]  wdata,
  output logic [DATA_W-1:0]  rdata
);

  logic [DATA_W-1:0] mem [NUMVROW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[row] <= wdata;
    end
  end

  // The addressed row is read every cycle.
  // A read in the same cycle as a write to that row returns the old word.
  always_ff @(posedge clk) begin
    rdata <= mem[row];
  end

endmodule

`default_nettype wire

/* source/np2_geom_pkg.sv */
`default_nettype none

package np2_geom_pkg;

  // Flat word address space seen by the requester.
  localparam int NUMADDR = 64;
  localparam int BITADDR = 6;

  // Five banks of twelve rows, so the top four addresses are unbacked.
  localparam int NUMVBNK = 5;
  localparam int BITVBNK = 3;
  localparam int NUMVROW = 12;
  localparam int BITVROW = 4;

  // The requester starts with one credit per queue slot.
  localparam int REQ_DEPTH   = 4;
  localparam int RSP_CREDITS = 2;

endpackage

`default_nettype wire

/* source/np2_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module np2_mem_top
  import np2_geom_pkg::*;
  import np2_op_pkg::*;
#(
  parameter int NUMADDR     = np2_geom_pkg::NUMADDR,
  parameter int BITADDR     = np2_geom_pkg::BITADDR,
  parameter int NUMVBNK     = np2_geom_pkg::NUMVBNK,
  parameter int BITVBNK     = np2_geom_pkg::BITVBNK,
  parameter int NUMVROW     = np2_geom_pkg::NUMVROW,
  parameter int BITVROW     = np2_geom_pkg::BITVROW,
  parameter int REQ_DEPTH   = np2_geom_pkg::REQ_DEPTH,
  parameter int RSP_CREDITS = np2_geom_pkg::RSP_CREDITS
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  np2_op_e            req_op,
  input  logic [BITADDR-1:0] req_addr,
  input  logic [DATA_W-1:0]  req_wdata,
  output logic               req_credit,
  output logic               rsp_valid,
  output np2_status_e        rsp_status,
  output logic [DATA_W-1:0]  rsp_rdata,
  input  logic               rsp_credit
);

  logic [BITADDR-1:0] map_addr;
  logic [BITVBNK-1:0] bank_sel;
  logic [BITVROW-1:0] row_sel;
  logic [NUMVBNK-1:0] bank_we;
  logic [BITVROW-1:0] bank_row;
  logic [DATA_W-1:0]  bank_wdata;
  logic [BITVBNK-1:0] rd_bank;
  logic [DATA_W-1:0]  bank_rdata;
  logic [DATA_W-1:0]  bank_rd [NUMVBNK];

  np2_req_ctrl #(
    .NUMVBNK     (NUMVBNK),
    .NUMVROW     (NUMVROW),
    .BITADDR     (BITADDR),
    .BITVBNK     (BITVBNK),
    .BITVROW     (BITVROW),
    .REQ_DEPTH   (REQ_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_status (rsp_status),
    .rsp_rdata  (rsp_rdata),
    .rsp_credit (rsp_credit),
    .map_addr   (map_addr),
    .bank_sel   (bank_sel),
    .row_sel    (row_sel),
    .bank_we    (bank_we),
    .bank_row   (bank_row),
    .bank_wdata (bank_wdata),
    .rd_bank    (rd_bank),
    .bank_rdata (bank_rdata)
  );

  np2_addr_ramwrap #(
    .NUMADDR (NUMADDR),
    .BITADDR (BITADDR),
    .NUMVBNK (NUMVBNK),
    .BITVBNK (BITVBNK),
    .BITPBNK (BITVBNK),
    .NUMVROW (NUMVROW),
    .BITVROW (BITVROW)
  ) u_map (
    .vaddr (map_addr),
    .vbadr (bank_sel),
    .vradr (row_sel)
  );

  for (genvar i = 0; i < NUMVBNK; i++) begin : g_bank
    np2_bank_ram #(
      .NUMVROW (NUMVROW),
      .BITVROW (BITVROW)
    ) u_bank (
      .clk   (clk),
      .we    (bank_we[i]),
      .row   (bank_row),
      .wdata (bank_wdata),
      .rdata (bank_rd[i])
    );
  end

  // Picks the bank that was addressed at the previous edge.
  always_comb begin
    bank_rdata = '0;
    for (int i = 0; i < NUMVBNK; i++) begin
      if (rd_bank == BITVBNK'(i)) begin
        bank_rdata = bank_rd[i];
      end
    end
  end

endmodule

`default_nettype wire

/* source/np2_op_pkg.sv */
`default_nettype none

package np2_op_pkg;

  // Width of one stored word.
  localparam int DATA_W = 16;

  // Command opcode carried with every request.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } np2_op_e;

  // Response status.
  // ST_RANGE marks an address past the last backed row of the last bank.
  typedef enum logic {
    ST_OK    = 1'b0,
    ST_RANGE = 1'b1
  } np2_status_e;

endpackage

`default_nettype wire

/* source/np2_req_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module np2_req_ctrl
  import np2_op_pkg::*;
#(
  parameter int NUMVBNK     = 5,
  parameter int NUMVROW     = 12,
  parameter int BITADDR     = 6,
  parameter int BITVBNK     = 3,
  parameter int BITVROW     = 4,
  parameter int REQ_DEPTH   = 4,
  parameter int RSP_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  np2_op_e            req_op,
  input  logic [BITADDR-1:0] req_addr,
  input  logic [DATA_W-1:0]  req_wdata,
  output logic               req_credit,
  output logic               rsp_valid,
  output np2_status_e        rsp_status,
  output logic [DATA_W-1:0]  rsp_rdata,
  input  logic               rsp_credit,
  output logic [BITADDR-1:0] map_addr,
  input  logic [BITVBNK-1:0] bank_sel,
  input  logic [BITVROW-1:0] row_sel,
  output logic [NUMVBNK-1:0] bank_we,
  output logic [BITVROW-1:0] bank_row,
  output logic [DATA_W-1:0]  bank_wdata,
  output logic [BITVBNK-1:0] rd_bank,
  input  logic [DATA_W-1:0]  bank_rdata
);

  localparam int NUMVADR = NUMVBNK * NUMVROW;
  localparam int PTR_W   = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W   = $clog2(REQ_DEPTH + 1);
  localparam int CRD_W   = $clog2(RSP_CREDITS + 1);

  np2_op_e           q_op    [REQ_DEPTH];
  logic [BITADDR-1:0] q_addr  [REQ_DEPTH];
  logic [DATA_W-1:0]  q_wdata [REQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic [CRD_W-1:0] out_cred;
  logic             pop;
  logic             head_in_range;
  logic             head_write;

  logic        s1_valid;
  np2_op_e     s1_op;
  np2_status_e s1_status;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(REQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // The requester only sends with a credit in hand, so a push never finds the queue full.
  always_ff @(posedge clk) begin
    if (req_valid) begin
      q_op[wr_ptr]    <= req_op;
      q_addr[wr_ptr]  <= req_addr;
      q_wdata[wr_ptr] <= req_wdata;
    end
  end

  // A response slot is reserved when its command issues, which keeps the two
  // commands in flight from overrunning the consumer.
  assign pop = (q_count != '0) && (out_cred != '0);

  assign req_credit    = pop;
  assign map_addr      = q_addr[rd_ptr];
  assign head_write    = (q_op[rd_ptr] == OP_WRITE);
  assign head_in_range = (32'(map_addr) < NUMVADR);

  assign bank_we    = (pop && head_write && head_in_range) ? (NUMVBNK'(1) << bank_sel) : '0;
  assign bank_row   = row_sel;
  assign bank_wdata = q_wdata[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      q_count  <= '0;
      out_cred <= CRD_W'(RSP_CREDITS);
    end else begin
      if (req_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({req_valid, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      case ({pop, rsp_credit})
        2'b10:   out_cred <= out_cred - 1'b1;
        2'b01:   out_cred <= out_cred + 1'b1;
        default: out_cred <= out_cred;
      endcase
    end
  end

  // Bank data for the issued command appears one cycle after the pop.
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      s1_valid  <= pop;
      rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1_op     <= q_op[rd_ptr];
      s1_status <= head_in_range ? ST_OK : ST_RANGE;
      rd_bank   <= bank_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      rsp_status <= s1_status;
      if (s1_op == OP_READ && s1_status == ST_OK) begin
        rsp_rdata <= bank_rdata;
      end else begin
        rsp_rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
source/np2_geom_pkg.sv
source/np2_op_pkg.sv
source/np2_addr_ramwrap.sv
source/np2_bank_ram.sv
source/np2_req_ctrl.sv
source/np2_mem_top.sv
test/tb_np2_mem.sv

/* test/np2_mem_patterns.txt */
// Columns: opcode (0 read, 1 write), address, write data, status (0 ok, 1 range), read data.
// Addresses 47, 48 and 59 sit on bank boundaries; 60 and 63 are past the last row.
1 00 a5a5 0 0000
0 00 0000 0 a5a5
1 2f 1234 0 0000
1 30 5678 0 0000
0 2f 0000 0 1234
0 30 0000 0 5678
1 3b beef 0 0000
0 3b 0000 0 beef
1 3c dead 1 0000
0 3c 0000 1 0000
1 3f ffff 1 0000
0 3b 0000 0 beef
1 0b 0b0b 0 0000
1 0c 0c0c 0 0000
0 0b 0000 0 0b0b
0 0c 0000 0 0c0c

/* test/tb_np2_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_np2_mem
  import np2_geom_pkg::*;
  import np2_op_pkg::*;
();

  localparam int NUMVADR = NUMVBNK * NUMVROW;
  localparam int NPAT    = 16;

  logic               clk        = 1'b0;
  logic               rst        = 1'b1;
  logic               req_valid  = 1'b0;
  np2_op_e            req_op     = OP_READ;
  logic [BITADDR-1:0] req_addr   = '0;
  logic [DATA_W-1:0]  req_wdata  = '0;
  logic               rsp_credit = 1'b0;
  logic               req_credit;
  logic               rsp_valid;
  np2_status_e        rsp_status;
  logic [DATA_W-1:0]  rsp_rdata;

  np2_op_e            cmd_op_q[$];
  logic [BITADDR-1:0] cmd_addr_q[$];
  logic [DATA_W-1:0]  cmd_wdata_q[$];
  int                 exp_addr_q[$];
  np2_status_e        exp_st_q[$];
  logic [DATA_W-1:0]  exp_rd_q[$];
  logic [DATA_W-1:0]  ref_mem [NUMVADR];
  logic [DATA_W-1:0]  pat [5*NPAT];
  logic [31:0]        lfsr = 32'hfe2d;
  int                 mon_addr;
  np2_status_e        mon_st;
  logic [DATA_W-1:0]  mon_rd;
  int credits = REQ_DEPTH;
  int held = 0;
  int delay_cnt = 0;
  int rsp_seen = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  bit withhold = 1'b0;
  bit rand_delay = 1'b0;

  np2_mem_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_status (rsp_status),
    .rsp_rdata  (rsp_rdata),
    .rsp_credit (rsp_credit)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1; one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic bit idle();
    return cmd_op_q.size() == 0 && exp_st_q.size() == 0 && held == 0 && credits == REQ_DEPTH;
  endfunction

  task automatic push_cmd(input np2_op_e op, input int addr, input logic [DATA_W-1:0] wdata,
                          input np2_status_e st, input logic [DATA_W-1:0] rd);
    cmd_op_q.push_back(op);
    cmd_addr_q.push_back(BITADDR'(addr));
    cmd_wdata_q.push_back(wdata);
    exp_addr_q.push_back(addr);
    exp_st_q.push_back(st);
    exp_rd_q.push_back(rd);
  endtask

  // Expected response follows from the address range and the reference memory.
  task automatic send_modeled(input np2_op_e op, input int addr, input logic [DATA_W-1:0] wdata);
    np2_status_e st;
    logic [DATA_W-1:0] rd;
    st = ST_OK;
    rd = '0;
    if (addr >= NUMVADR) begin
      st = ST_RANGE;
    end else if (op == OP_WRITE) begin
      ref_mem[addr] = wdata;
    end else begin
      rd = ref_mem[addr];
    end
    push_cmd(op, addr, wdata, st, rd);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
  endtask

  task automatic wait_idle(input string what, input int limit);
    int n;
    n = 0;
    while (!idle() && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!idle()) report_timeout(what);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, errors - err_before);
  endtask

  // Requester, response checker and consumer share one falling-edge process.
  always @(negedge clk) begin
    if (req_credit) begin
      if (credits >= REQ_DEPTH) begin
        $display("req_credit returned a credit that was never spent");
        errors++;
      end else begin
        credits++;
      end
    end
    if (rsp_valid) begin
      rsp_seen++;
      held++;
      if (exp_st_q.size() == 0) begin
        $display("a response arrived with no command outstanding");
        errors++;
      end else begin
        mon_addr = exp_addr_q.pop_front();
        mon_st = exp_st_q.pop_front();
        mon_rd = exp_rd_q.pop_front();
        checks++;
        if (rsp_status !== mon_st) begin
          $display("[FAIL] rsp_status addr %h expected %h got %h", mon_addr, mon_st, rsp_status);
          errors++;
        end
        if (rsp_rdata !== mon_rd) begin
          $display("[FAIL] rsp_rdata addr %h expected %h got %h", mon_addr, mon_rd, rsp_rdata);
          errors++;
        end
      end
    end
    rsp_credit = 1'b0;
    if (delay_cnt > 0) begin
      delay_cnt--;
    end else if (held > 0 && !withhold) begin
      rsp_credit = 1'b1;
      held--;
      if (rand_delay) delay_cnt = int'(rand_bits(2));
    end
    req_valid = 1'b0;
    if (cmd_op_q.size() > 0 && credits > 0) begin
      req_valid = 1'b1;
      req_op = cmd_op_q.pop_front();
      req_addr = cmd_addr_q.pop_front();
      req_wdata = cmd_wdata_q.pop_front();
      credits--;
    end
  end

  initial begin
    int err0;
    int seen0;
    int n;
    np2_op_e p_op;
    int p_addr;
    $readmemh("test/np2_mem_patterns.txt", pat);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);

    err0 = errors;
    rand_delay = 1'b1;
    for (int pass = 0; pass < 2; pass++) begin
      for (int a = 0; a < NUMVADR; a++) send_modeled(OP_WRITE, a, DATA_W'(rand_bits(DATA_W)));
    end
    for (int a = 0; a < NUMVADR; a++) send_modeled(OP_READ, a, '0);
    wait_idle("full-range sweep", 4000);
    end_test("sweep", err0);

    err0 = errors;
    for (int a = NUMVADR; a < NUMADDR; a++) begin
      send_modeled(OP_WRITE, a, DATA_W'(32'hdead ^ a));
      send_modeled(OP_READ, a, '0);
    end
    for (int a = 0; a < NUMVADR; a++) send_modeled(OP_READ, a, '0);
    wait_idle("out-of-range commands", 2000);
    end_test("range", err0);

    err0 = errors;
    send_modeled(OP_WRITE, 5, 16'h5a5a);
    send_modeled(OP_READ, 5, '0);
    wait_idle("write response", 100);
    end_test("write_rsp", err0);

    // The burst starts with a full credit count, so it goes out back to back.
    err0 = errors;
    rand_delay = 1'b0;
    seen0 = rsp_seen;
    for (int i = 0; i < REQ_DEPTH; i++) send_modeled(OP_WRITE, 20 + i, DATA_W'(rand_bits(DATA_W)));
    for (int i = 0; i < REQ_DEPTH; i++) send_modeled(OP_READ, 20 + i, '0);
    wait_idle("ordered burst", 200);
    if (rsp_seen - seen0 != 2 * REQ_DEPTH) begin
      $display("burst gave %0d responses for %0d commands", rsp_seen - seen0, 2 * REQ_DEPTH);
      errors++;
    end
    end_test("order", err0);

    err0 = errors;
    seen0 = rsp_seen;
    withhold = 1'b1;
    for (int a = 0; a < 8; a++) send_modeled(OP_READ, a, '0);
    n = 0;
    while (!(credits == 0 && cmd_op_q.size() == 8 - REQ_DEPTH - RSP_CREDITS) && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (n >= 100) report_timeout("requester credits to run out");
    n = 0;
    while (rsp_seen - seen0 < RSP_CREDITS && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (n >= 100) report_timeout("responses under back-pressure");
    repeat (10) @(posedge clk);
    if (rsp_seen - seen0 > RSP_CREDITS) begin
      $display("back-pressure let %0d responses through", rsp_seen - seen0);
      errors++;
    end
    if (credits != 0) begin
      $display("requester credits came back while responses were withheld");
      errors++;
    end
    withhold = 1'b0;
    wait_idle("drain after back-pressure", 200);
    end_test("backpressure", err0);

    err0 = errors;
    for (int i = 0; i < NPAT; i++) begin
      p_op = np2_op_e'(pat[5*i][0]);
      p_addr = int'(pat[5*i+1]);
      if (p_op == OP_WRITE && p_addr < NUMVADR) ref_mem[p_addr] = pat[5*i+2];
      push_cmd(p_op, p_addr, pat[5*i+2], np2_status_e'(pat[5*i+3][0]), pat[5*i+4]);
    end
    wait_idle("directed patterns", 500);
    end_test("patterns", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
